//--- attr_pkg.sv
//////////////////////////////////////////////////////////////////////
// Attribute interpolator shared definitions
// Widths and fixed-point constants of the pipeline
// Rasterizer command codes
// Pixel tag, attribute set and fragment structs
//////////////////////////////////////////////////////////////////////
package attr_pkg;

    localparam int ATTR_W      = 32; // Accumulator width
    localparam int POS_W       = 11; // Screen coordinate width
    localparam int INDEX_W     = 32;
    localparam int CALC_W      = 18; // Reciprocal and multiply precision
    localparam int POINT_POS   = 9;  // Fraction bits of the reciprocal
    localparam int DEPTH_W     = 16;
    localparam int SUB_PIXEL_W = 8;

    // Qn.26 dividend, so Qn.26 / U1.17 gives U9.9
    localparam logic [ATTR_W-1:0] RECIP_NUM =
        (32'd1 << (CALC_W - 1 + POINT_POS)) - 32'd1;

    // U9.9 * S1.16 = S10.25, shifted down to S16.15
    localparam int PERSP_SHIFT = (CALC_W - 2) + POINT_POS - 15;

    //////////////////////////////////////////////////////////////////////
    // Rasterizer commands
    //////////////////////////////////////////////////////////////////////
    typedef enum logic [1:0] {
        CMD_INIT  = 2'd0, // Load start values
        CMD_X_INC = 2'd1,
        CMD_X_DEC = 2'd2,
        CMD_Y_INC = 2'd3
    } cmd_t;

    // Pass-through part of a beat
    typedef struct packed {
        logic               last;
        logic               keep;
        logic [POS_W-1:0]   spx;
        logic [POS_W-1:0]   spy;
        logic [INDEX_W-1:0] index;
    } pix_tag_t;

    // Start values, increments and accumulators share this layout
    typedef struct packed {
        logic signed [ATTR_W-1:0] tex_s;   // S1.30
        logic signed [ATTR_W-1:0] tex_t;
        logic signed [ATTR_W-1:0] tex_q;
        logic signed [ATTR_W-1:0] depth_z; // S1.30
        logic signed [ATTR_W-1:0] color_r; // S7.24
        logic signed [ATTR_W-1:0] color_g;
        logic signed [ATTR_W-1:0] color_b;
        logic signed [ATTR_W-1:0] color_a;
    } attr_set_t;

    typedef struct packed {
        logic [ATTR_W-1:0]      tex_s;   // S16.15
        logic [ATTR_W-1:0]      tex_t;
        logic [DEPTH_W-1:0]     depth_z; // U0.16
        logic [SUB_PIXEL_W-1:0] color_r;
        logic [SUB_PIXEL_W-1:0] color_g;
        logic [SUB_PIXEL_W-1:0] color_b;
        logic [SUB_PIXEL_W-1:0] color_a;
    } frag_t;

endpackage

//--- attr_stepper.sv
//////////////////////////////////////////////////////////////////////
// Command-driven attribute accumulators
// Eight fixed-point accumulators stepped by INIT, X_INC, X_DEC, Y_INC
// Input tag register and pixel valid register
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module attr_stepper
(
    input  logic                aclk,
    input  logic                rst_n,

    // Rasterizer beat
    input  logic                s_valid,
    input  attr_pkg::cmd_t      s_cmd,
    input  logic                s_pixel,
    input  attr_pkg::pix_tag_t  s_tag,

    // Triangle attributes, held while stepping
    input  attr_pkg::attr_set_t attr_start,
    input  attr_pkg::attr_set_t attr_inc_x,
    input  attr_pkg::attr_set_t attr_inc_y,

    output attr_pkg::attr_set_t acc,
    output logic                acc_valid,
    output attr_pkg::pix_tag_t  acc_tag
);
    import attr_pkg::*;

    attr_set_t acc_nxt;

    // Field-wise add or subtract over the whole attribute set
    function automatic attr_set_t step_set
    (
        input attr_set_t base,
        input attr_set_t delta,
        input logic      sub
    );
        attr_set_t res;
        for (int i = 0; i < $bits(attr_set_t) / ATTR_W; i++)
        begin
            if (sub)
                res[i*ATTR_W +: ATTR_W] = base[i*ATTR_W +: ATTR_W] - delta[i*ATTR_W +: ATTR_W];
            else
                res[i*ATTR_W +: ATTR_W] = base[i*ATTR_W +: ATTR_W] + delta[i*ATTR_W +: ATTR_W];
        end
        return res;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Next accumulator value from the command
    //////////////////////////////////////////////////////////////////////
    always_comb
    begin
        acc_nxt = acc;
        case (s_cmd)
            CMD_INIT:  acc_nxt = attr_start;
            CMD_X_INC: acc_nxt = step_set(acc, attr_inc_x, 1'b0);
            CMD_X_DEC: acc_nxt = step_set(acc, attr_inc_x, 1'b1); // Walking back along the span
            CMD_Y_INC: acc_nxt = step_set(acc, attr_inc_y, 1'b0);
        endcase
    end

    // Non-pixel beats still step the accumulators
    always_ff @(posedge aclk)
    begin
        if (!rst_n)
        begin
            acc       <= '0;
            acc_valid <= 1'b0;
        end
        else
        begin
            acc_valid <= s_valid & s_pixel;
            if (s_valid)
                acc <= acc_nxt;
        end
    end

    always_ff @(posedge aclk)
    begin
        acc_tag <= s_tag;
    end

endmodule

//--- recip_stage.sv
//////////////////////////////////////////////////////////////////////
// Pipeline stage A of the attribute interpolator
// Texture s and t extraction to S1.16
// Saturating reciprocal of q by exact truncating division
// Depth and color clamping into the fragment
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module recip_stage
(
    input  logic                              aclk,
    input  logic                              rst_n,

    input  attr_pkg::attr_set_t               acc,
    input  logic                              acc_valid,
    input  attr_pkg::pix_tag_t                acc_tag,

    output logic                              a_valid,
    output attr_pkg::pix_tag_t                a_tag,
    output logic signed [attr_pkg::CALC_W-1:0] a_s,
    output logic signed [attr_pkg::CALC_W-1:0] a_t,
    output logic        [attr_pkg::CALC_W-1:0] a_recip, // U9.9
    output attr_pkg::frag_t                   a_frag
);
    import attr_pkg::*;

    logic signed [CALC_W-1:0] s18;
    logic signed [CALC_W-1:0] t18;
    logic        [CALC_W-1:0] q18;     // U1.17
    logic        [ATTR_W-1:0] divisor;
    logic        [ATTR_W-1:0] quot;
    logic        [CALC_W-1:0] recip;
    frag_t                    frag_c;

    // S7.8 word to an 8 bit channel
    function automatic logic [SUB_PIXEL_W-1:0] clamp_color(input logic [ATTR_W-1:0] v);
        logic [15:0] word;
        word = v[ATTR_W-1 -: 16];
        if (word[15])
            return '0; // Negative
        else if (|word[14:SUB_PIXEL_W])
            return '1; // Above 1.0
        else
            return word[SUB_PIXEL_W-1:0];
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Reciprocal of q
    //////////////////////////////////////////////////////////////////////
    always_comb
    begin
        s18 = acc.tex_s[ATTR_W-1 -: CALC_W];
        t18 = acc.tex_t[ATTR_W-1 -: CALC_W];
        q18 = acc.tex_q[ATTR_W-2 -: CALC_W]; // Sign dropped, q is normalized

        divisor = (q18 == '0) ? 32'd1 : {{(ATTR_W - CALC_W){1'b0}}, q18};
        quot    = RECIP_NUM / divisor;

        // Saturate on zero q or a quotient wider than 18 bits
        if (q18 == '0 || |quot[ATTR_W-1:CALC_W])
            recip = '1;
        else
            recip = quot[CALC_W-1:0];
    end

    always_comb
    begin
        frag_c         = '0; // Texture filled in by stage B
        frag_c.depth_z = acc.depth_z[ATTR_W-1] ? '0 :
                         acc.depth_z[ATTR_W-2] ? '1 :
                         acc.depth_z[14 +: DEPTH_W];
        frag_c.color_r = clamp_color(acc.color_r);
        frag_c.color_g = clamp_color(acc.color_g);
        frag_c.color_b = clamp_color(acc.color_b);
        frag_c.color_a = clamp_color(acc.color_a);
    end

    always_ff @(posedge aclk)
    begin
        if (!rst_n)
            a_valid <= 1'b0;
        else
            a_valid <= acc_valid;
    end

    always_ff @(posedge aclk)
    begin
        a_tag   <= acc_tag;
        a_s     <= s18;
        a_t     <= t18;
        a_recip <= recip;
        a_frag  <= frag_c;
    end

endmodule

//--- persp_stage.sv
//////////////////////////////////////////////////////////////////////
// Pipeline stage B of the attribute interpolator
// Perspective correction of s and t by the reciprocal of q
// Output fragment, tag and valid registers
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module persp_stage
(
    input  logic                               aclk,
    input  logic                               rst_n,

    input  logic                               a_valid,
    input  attr_pkg::pix_tag_t                 a_tag,
    input  logic signed [attr_pkg::CALC_W-1:0] a_s,
    input  logic signed [attr_pkg::CALC_W-1:0] a_t,
    input  logic        [attr_pkg::CALC_W-1:0] a_recip,
    input  attr_pkg::frag_t                    a_frag,

    output logic                               m_valid,
    output attr_pkg::pix_tag_t                 m_tag,
    output attr_pkg::frag_t                    m_frag
);
    import attr_pkg::*;

    frag_t frag_c;

    // S1.16 times U9.9, result in S16.15
    function automatic logic [ATTR_W-1:0] persp_mul
    (
        input logic signed [CALC_W-1:0] v,
        input logic        [CALC_W-1:0] r
    );
        logic signed [2*CALC_W:0] prod;
        prod = v * $signed({1'b0, r});
        prod = prod >>> PERSP_SHIFT;
        return prod[ATTR_W-1:0];
    endfunction

    always_comb
    begin
        frag_c       = a_frag; // Depth and colors already final
        frag_c.tex_s = persp_mul(a_s, a_recip);
        frag_c.tex_t = persp_mul(a_t, a_recip);
    end

    always_ff @(posedge aclk)
    begin
        if (!rst_n)
            m_valid <= 1'b0;
        else
            m_valid <= a_valid;
    end

    always_ff @(posedge aclk)
    begin
        m_tag  <= a_tag;
        m_frag <= frag_c;
    end

endmodule

//--- attr_interp_top.sv
//////////////////////////////////////////////////////////////////////
// Attribute interpolator top level
// Stepper, reciprocal stage and perspective stage in a line
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module attr_interp_top
(
    input  logic                aclk,
    input  logic                rst_n,

    // Triangle attributes
    input  attr_pkg::attr_set_t attr_start,
    input  attr_pkg::attr_set_t attr_inc_x,
    input  attr_pkg::attr_set_t attr_inc_y,

    // Rasterizer beats
    input  logic                s_valid,
    input  attr_pkg::cmd_t      s_cmd,
    input  logic                s_pixel,
    input  attr_pkg::pix_tag_t  s_tag,

    // Fragments
    output logic                m_valid,
    output attr_pkg::pix_tag_t  m_tag,
    output attr_pkg::frag_t     m_frag
);
    import attr_pkg::*;

    attr_set_t                acc;
    logic                     acc_valid;
    pix_tag_t                 acc_tag;

    logic                     a_valid;
    pix_tag_t                 a_tag;
    logic signed [CALC_W-1:0] a_s;
    logic signed [CALC_W-1:0] a_t;
    logic        [CALC_W-1:0] a_recip;
    frag_t                    a_frag;

    //////////////////////////////////////////////////////////////////////
    // Three stage pipeline
    //////////////////////////////////////////////////////////////////////
    attr_stepper u_stepper
    (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .s_valid    (s_valid),
        .s_cmd      (s_cmd),
        .s_pixel    (s_pixel),
        .s_tag      (s_tag),
        .attr_start (attr_start),
        .attr_inc_x (attr_inc_x),
        .attr_inc_y (attr_inc_y),
        .acc        (acc),
        .acc_valid  (acc_valid),
        .acc_tag    (acc_tag)
    );

    recip_stage u_recip
    (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .acc       (acc),
        .acc_valid (acc_valid),
        .acc_tag   (acc_tag),
        .a_valid   (a_valid),
        .a_tag     (a_tag),
        .a_s       (a_s),
        .a_t       (a_t),
        .a_recip   (a_recip),
        .a_frag    (a_frag)
    );

    persp_stage u_persp
    (
        .aclk    (aclk),
        .rst_n   (rst_n),
        .a_valid (a_valid),
        .a_tag   (a_tag),
        .a_s     (a_s),
        .a_t     (a_t),
        .a_recip (a_recip),
        .a_frag  (a_frag),
        .m_valid (m_valid),
        .m_tag   (m_tag),
        .m_frag  (m_frag)
    );

endmodule

//--- attr_checker.sv
//////////////////////////////////////////////////////////////////////
// Attribute interpolator checker
// Reference accumulators and fragment rules
// Expected fragment queue and field comparisons
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module attr_checker
(
    input  logic                aclk,
    input  logic                rst_n,
    input  logic [127:0]        test_name,

    // DUT inputs
    input  logic                s_valid,
    input  attr_pkg::cmd_t      s_cmd,
    input  logic                s_pixel,
    input  attr_pkg::pix_tag_t  s_tag,
    input  attr_pkg::attr_set_t attr_start,
    input  attr_pkg::attr_set_t attr_inc_x,
    input  attr_pkg::attr_set_t attr_inc_y,

    // DUT outputs
    input  logic                m_valid,
    input  attr_pkg::pix_tag_t  m_tag,
    input  attr_pkg::frag_t     m_frag,

    output int                  value_errs,
    output int                  extra_outs,
    output int                  pending,
    output int                  checked
);
    import attr_pkg::*;

    typedef struct packed {
        logic [127:0] name;
        pix_tag_t     tag;
        frag_t        frag;
    } expect_t;

    attr_set_t model_acc;
    expect_t   item;
    expect_t   exp_q [$];

    // Step every field, dir is +1 or -1
    function automatic attr_set_t move_set(input attr_set_t a, input attr_set_t d, input int dir);
        attr_set_t r;
        r.tex_s   = a.tex_s + dir * d.tex_s;
        r.tex_t   = a.tex_t + dir * d.tex_t;
        r.tex_q   = a.tex_q + dir * d.tex_q;
        r.depth_z = a.depth_z + dir * d.depth_z;
        r.color_r = a.color_r + dir * d.color_r;
        r.color_g = a.color_g + dir * d.color_g;
        r.color_b = a.color_b + dir * d.color_b;
        r.color_a = a.color_a + dir * d.color_a;
        return r;
    endfunction

    // Texture coordinate times 1/q, both reduced to 18 bits
    function automatic logic [31:0] persp_ref(input logic [31:0] coord, input logic [31:0] q);
        longint sv;
        longint qv;
        longint rv;
        longint prod;
        sv = longint'($signed(coord[31:14]));
        qv = longint'(q[30:13]);
        rv = (qv == 0) ? 262143 : longint'(RECIP_NUM) / qv;
        if (rv > 262143)
            rv = 262143; // Saturate to 18 bits
        prod = (sv * rv) >>> PERSP_SHIFT;
        return prod[31:0];
    endfunction

    function automatic logic [15:0] depth_ref(input logic [31:0] z);
        if (z[31])
            return 16'h0000;
        if (z[30])
            return 16'hFFFF; // At or above 1.0
        return z[29:14];
    endfunction

    function automatic logic [7:0] color_ref(input logic [31:0] c);
        if (c[31])
            return 8'd0;
        if (c[30:24] != 7'd0)
            return 8'd255;
        return c[23:16];
    endfunction

    task automatic check_field(input logic [127:0] name, input string field,
                               input logic [63:0] exp_v, input logic [63:0] act_v);
        if (exp_v !== act_v)
        begin
            $display("[ERROR] %0s %0s expected %h actual %h", name, field, exp_v, act_v);
            value_errs++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Output compare first, then model update for the input beat
    //////////////////////////////////////////////////////////////////////
    always @(posedge aclk)
    begin
        if (!rst_n)
        begin
            model_acc = '0;
            exp_q.delete();
        end
        else
        begin
            if (m_valid && exp_q.size() == 0)
            begin
                $display("Fragment with index %0d came out with no pixel beat pending",
                         m_tag.index);
                extra_outs++;
            end
            else if (m_valid)
            begin
                item = exp_q.pop_front();
                check_field(item.name, "tag", item.tag, m_tag);
                check_field(item.name, "tex_s", item.frag.tex_s, m_frag.tex_s);
                check_field(item.name, "tex_t", item.frag.tex_t, m_frag.tex_t);
                check_field(item.name, "depth_z", item.frag.depth_z, m_frag.depth_z);
                check_field(item.name, "color_r", item.frag.color_r, m_frag.color_r);
                check_field(item.name, "color_g", item.frag.color_g, m_frag.color_g);
                check_field(item.name, "color_b", item.frag.color_b, m_frag.color_b);
                check_field(item.name, "color_a", item.frag.color_a, m_frag.color_a);
                checked++;
            end
            if (s_valid)
            begin
                case (s_cmd)
                    CMD_INIT:  model_acc = attr_start;
                    CMD_X_INC: model_acc = move_set(model_acc, attr_inc_x, 1);
                    CMD_X_DEC: model_acc = move_set(model_acc, attr_inc_x, -1);
                    default:   model_acc = move_set(model_acc, attr_inc_y, 1);
                endcase
                if (s_pixel)
                begin
                    item.name         = test_name;
                    item.tag          = s_tag;
                    item.frag.tex_s   = persp_ref(model_acc.tex_s, model_acc.tex_q);
                    item.frag.tex_t   = persp_ref(model_acc.tex_t, model_acc.tex_q);
                    item.frag.depth_z = depth_ref(model_acc.depth_z);
                    item.frag.color_r = color_ref(model_acc.color_r);
                    item.frag.color_g = color_ref(model_acc.color_g);
                    item.frag.color_b = color_ref(model_acc.color_b);
                    item.frag.color_a = color_ref(model_acc.color_a);
                    exp_q.push_back(item);
                end
            end
        end
        pending = exp_q.size();
    end

endmodule

//--- tb_attr_interp.sv
//////////////////////////////////////////////////////////////////////
// Attribute interpolator testbench
// Clock, reset, directed and LCG attribute sets
// Stimulus table, drive loop and cycle timeout
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module tb_attr_interp;
    import attr_pkg::*;

    localparam int RESET_CYCLES = 16;

    // One beat of the stimulus table
    typedef struct packed {
        logic [127:0] name;
        cmd_t         cmd;
        logic         pixel;
        pix_tag_t     tag;
        logic [1:0]   set_sel; // Attribute set of the triangle
    } row_t;

    logic         aclk;
    logic         rst_n;
    attr_set_t    attr_start, attr_inc_x, attr_inc_y;
    logic         s_valid, s_pixel, m_valid;
    cmd_t         s_cmd;
    pix_tag_t     s_tag, m_tag;
    frag_t        m_frag;
    logic [127:0] test_name;
    int           value_errs, extra_outs, pending, checked;
    int           cycle_cnt, cycle_limit, next_index;
    logic [31:0]  rng;
    attr_set_t    set_start [4], set_inc_x [4], set_inc_y [4];
    row_t         table_q [$];

    attr_interp_top UUT (.*);
    attr_checker u_checker (.*);

    initial aclk = 1'b0;
    always #2 aclk = ~aclk;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic add_row(input logic [127:0] name, input cmd_t cmd, input logic pixel,
                           input logic last, input logic [1:0] set_sel);
        row_t r;
        r.name    = name;
        r.cmd     = cmd;
        r.pixel   = pixel;
        r.tag     = '{last, next_index[0], POS_W'(next_index * 7),
                      POS_W'(next_index * 13 + 100), 32'h1000 + next_index};
        r.set_sel = set_sel;
        table_q.push_back(r);
        next_index++;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Attribute sets, s t q z r g b a
    //////////////////////////////////////////////////////////////////////
    task automatic fill_sets;
        // Set 0 walks colors and depth across the clamp limits
        set_start[0] = '{32'h1000_0000, 32'hF000_0000, 32'h4000_0000, 32'h2345_6789,
                         32'h0042_0000, 32'h0080_0000, 32'h00C0_0000, 32'h00FF_0000};
        set_inc_x[0] = '{32'h0010_0000, 32'hFFF0_0000, 32'h0100_0000, 32'h0010_0000,
                         32'h0001_0000, 32'h0040_0000, 32'hFFF0_0000, 32'h0001_0000};
        set_inc_y[0] = '{32'h0200_0000, 32'h0200_0000, 32'h0400_0000, 32'h0400_0000,
                         32'hFFC0_0000, 32'h0000_0000, 32'h0100_0000, 32'h0000_0000};
        // Set 1 starts at q18 = 0 and steps q18 by one, negative s
        set_start[1] = '{32'hE000_0000, 32'h2000_0000, 32'h0000_0000, 32'hC000_0000,
                         32'hFFFF_0000, 32'h7FFF_0000, 32'h0000_0000, 32'h0001_0000};
        set_inc_x[1] = '{32'hFF00_0000, 32'h0100_0000, 32'h0000_2000, 32'h4000_0000,
                         32'h0002_0000, 32'h0000_0000, 32'h00FF_0000, 32'h0000_8000};
        set_inc_y[1] = '{32'h0400_0000, 32'hF800_0000, 32'h3000_0000, 32'hB000_0000,
                         32'h0080_0000, 32'hFF00_0000, 32'h0000_0000, 32'h0000_0000};
        for (int k = 2; k < 4; k++)
        begin
            for (int i = 0; i < 8; i++)
            begin
                rng = lcg_next(rng);
                set_start[k][i*32 +: 32] = rng;
                rng = lcg_next(rng);
                set_inc_x[k][i*32 +: 32] = $signed(rng) >>> 5; // Smaller steps
                rng = lcg_next(rng);
                set_inc_y[k][i*32 +: 32] = $signed(rng) >>> 5;
            end
        end
    endtask

    task automatic build_table;
        add_row("init_pix",    CMD_INIT,  1'b1, 1'b0, 2'd0);
        add_row("x_inc_1",     CMD_X_INC, 1'b1, 1'b0, 2'd0);
        add_row("x_inc_2",     CMD_X_INC, 1'b1, 1'b0, 2'd0);
        add_row("x_dec_back",  CMD_X_DEC, 1'b1, 1'b0, 2'd0); // Same as x_inc_1
        add_row("y_inc_1",     CMD_Y_INC, 1'b1, 1'b0, 2'd0);
        add_row("y_inc_skip",  CMD_Y_INC, 1'b0, 1'b0, 2'd0);
        add_row("y_inc_2",     CMD_Y_INC, 1'b1, 1'b1, 2'd0);
        add_row("q_zero_init", CMD_INIT,  1'b1, 1'b0, 2'd1);
        add_row("q_small_1",   CMD_X_INC, 1'b1, 1'b0, 2'd1);
        add_row("q_small_2",   CMD_X_INC, 1'b1, 1'b0, 2'd1);
        add_row("x_inc_skip",  CMD_X_INC, 1'b0, 1'b0, 2'd1);
        add_row("depth_mid_y", CMD_Y_INC, 1'b1, 1'b0, 2'd1);
        add_row("depth_neg_x", CMD_X_DEC, 1'b1, 1'b1, 2'd1);
        add_row("lcg_init",    CMD_INIT,  1'b1, 1'b0, 2'd2);
        add_row("burst_x",     CMD_X_INC, 1'b1, 1'b0, 2'd2);
        add_row("burst_y",     CMD_Y_INC, 1'b1, 1'b0, 2'd2);
        add_row("burst_back",  CMD_X_DEC, 1'b1, 1'b1, 2'd2);
        add_row("rand_init",   CMD_INIT,  1'b1, 1'b0, 2'd3);
        for (int i = 0; i < 16; i++)
        begin
            rng = lcg_next(rng);
            add_row("rand_beat", cmd_t'(rng[31:30]), rng[29] | rng[28], i == 15, 2'd3);
        end
    endtask

    task automatic next_cycle;
        @(posedge aclk);
        #1;
    endtask

    task automatic drive_beat(input row_t r);
        s_valid    = 1'b1;
        s_cmd      = r.cmd;
        s_pixel    = r.pixel;
        s_tag      = r.tag;
        attr_start = set_start[r.set_sel];
        attr_inc_x = set_inc_x[r.set_sel];
        attr_inc_y = set_inc_y[r.set_sel];
        test_name  = r.name;
        next_cycle();
    endtask

    task automatic drive_idle;
        s_valid = 1'b0;
        s_pixel = 1'b0;
        next_cycle();
    endtask

    //////////////////////////////////////////////////////////////////////
    // Reset, drive loop and closing report
    //////////////////////////////////////////////////////////////////////
    initial
    begin
        rst_n      = 1'b0;
        s_valid    = 1'b0;
        s_cmd      = CMD_INIT;
        s_pixel    = 1'b0;
        s_tag      = '0;
        attr_start = '0;
        attr_inc_x = '0;
        attr_inc_y = '0;
        test_name  = "reset";
        rng        = 32'hb19430eb;
        fill_sets();
        build_table();
        cycle_limit = RESET_CYCLES + 2 * table_q.size() + 40; // At most one gap per row
        repeat (RESET_CYCLES) @(posedge aclk);
        #1;
        rst_n = 1'b1;
        foreach (table_q[i])
        begin
            drive_beat(table_q[i]);
            rng = lcg_next(rng);
            if (rng[31:29] == 3'd0)
                drive_idle(); // Occasional gap
        end
        for (int n = 0; n < 8 && pending != 0; n++)
            drive_idle();
        repeat (4) drive_idle(); // Catch stray outputs
        if (pending != 0)
            $display("%0d expected fragments never reached the output", pending);
        $display("Checked %0d fragments: %0d wrong values, %0d unexpected, %0d missing",
                 checked, value_errs, extra_outs, pending);
        if (value_errs == 0 && extra_outs == 0 && pending == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

    always @(posedge aclk)
    begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit)
        begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Errors found");
            $finish;
        end
    end

endmodule

//--- vlog.f
attr_pkg.sv
attr_stepper.sv
recip_stage.sv
persp_stage.sv
attr_interp_top.sv
attr_checker.sv
tb_attr_interp.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the attribute interpolator testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

if ! verilator --binary --timing -Wno-fatal -f vlog.f --top-module tb_attr_interp; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/Vtb_attr_interp > "$LOG" 2>&1; then
    cat "$LOG"
    echo "Simulation exited with an error status"
    exit 1
fi
cat "$LOG"

if grep -q "Errors found" "$LOG"; then
    echo "Simulation FAILED"
    exit 1
fi
echo "Simulation PASSED"
exit 0
